//--- logic/bitplane_slice.sv
// picks the active plane bit of each colour for both halves and drives pixel clock, latch and row
`timescale 1ns/1ps

module bitplane_slice (
	input  logic                                 clk_root,
	input  logic                                 rst,
	input  logic                                 pair_valid,
	input  led_matrix_pkg::pixel_word_u          pixel_top,
	input  led_matrix_pkg::pixel_word_u          pixel_bottom,
	input  logic [led_matrix_pkg::plane_bits-1:0] pair_plane,
	input  logic                                 pair_last,
	input  logic [led_matrix_pkg::scan_bits-1:0]  pair_row,
	input  logic [led_matrix_pkg::planes-1:0]     brightness_enable,
	output logic [2:0]                           rgb_top,
	output logic [2:0]                           rgb_bottom,
	output logic                                 pixel_clk,
	output logic                                 row_latch,
	output logic [led_matrix_pkg::scan_bits-1:0]  row_addr,
	output logic                                 latch_done
);
	import led_matrix_pkg::*;

	logic bits_valid;
	logic bits_last;
	logic [scan_bits-1:0] bits_row;
	logic clk_last;
	logic [scan_bits-1:0] clk_row;

	// red in bit 0, green in bit 1, blue in bit 2
	function automatic logic [2:0] slice_bits(input pixel_word_u px,
			input logic [plane_bits-1:0] sel);
		logic [5:0] red6;
		logic [5:0] blue6;
		// 5 bit channels get their msb repeated below the lsb
		red6 = {px.field.red, px.field.red[4]};
		blue6 = {px.field.blue, px.field.blue[4]};
		return {blue6[sel], px.field.green[sel], red6[sel]};
	endfunction

	always_ff @(posedge clk_root) begin
		if (pair_valid) begin
			if (brightness_enable[pair_plane]) begin
				rgb_top <= slice_bits(pixel_top, pair_plane);
				rgb_bottom <= slice_bits(pixel_bottom, pair_plane);
			end else begin
				rgb_top <= 3'b000;
				rgb_bottom <= 3'b000;
			end
		end
		bits_last <= pair_last;
		bits_row <= pair_row;
		clk_row <= bits_row;
	end

	always_ff @(posedge clk_root) begin
		if (rst) begin
			bits_valid <= 1'b0;
			pixel_clk <= 1'b0;
			clk_last <= 1'b0;
			row_latch <= 1'b0;
			latch_done <= 1'b0;
			row_addr <= '0;
		end else begin
			bits_valid <= pair_valid;
			// colour bits are stable for a full cycle before the clock edge
			pixel_clk <= bits_valid;
			clk_last <= bits_valid && bits_last;
			row_latch <= clk_last;
			latch_done <= clk_last;
			if (clk_last) begin
				row_addr <= clk_row;
			end
		end
	end

endmodule

//--- logic/frame_buffer.sv
// double-banked pixel memory, one write port from the loader and one registered read port for fetch
`timescale 1ns/1ps

module frame_buffer (
	input  logic                                clk_root,
	input  logic                                wr_en,
	input  logic [led_matrix_pkg::addr_bits-1:0] wr_addr,
	input  led_matrix_pkg::pixel_word_u         wr_data,
	input  logic [led_matrix_pkg::addr_bits-1:0] rd_addr,
	output led_matrix_pkg::pixel_word_u         rd_data
);
	import led_matrix_pkg::*;

	// two banks of columns x (2 * scan_rows) words
	pixel_word_u mem [2 ** addr_bits];

	// both banks start black as in a zeroed block RAM
	initial begin
		for (int i = 0; i < 2 ** addr_bits; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk_root) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// one cycle read latency
	always_ff @(posedge clk_root) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- logic/frame_loader.sv
// byte command parser with credit flow control, writes pixels to the back bank and owns bank swap
`timescale 1ns/1ps

module frame_loader (
	input  logic                                clk_root,
	input  logic                                rst,
	input  logic                                byte_valid,
	input  logic [7:0]                          byte_data,
	output logic                                byte_credit,
	input  logic                                frame_start,
	output logic                                wr_en,
	output logic [led_matrix_pkg::addr_bits-1:0] wr_addr,
	output led_matrix_pkg::pixel_word_u         wr_data,
	output logic                                display_bank,
	output logic [led_matrix_pkg::planes-1:0]   brightness_enable
);
	import led_matrix_pkg::*;

	logic [7:0] queue [credit_depth];
	logic [queue_bits-1:0] head_ptr;
	logic [queue_bits-1:0] tail_ptr;
	logic [count_bits-1:0] count;
	logic [7:0] head;
	logic head_valid;
	logic swap_wait;
	logic retire;

	logic [1:0] state;
	logic [row_bits-1:0] load_row;
	logic [col_bits-1:0] load_col;
	logic lane;

	assign head = queue[head_ptr];
	assign head_valid = count != '0;
	// a swap sits at the head until the sequencer reaches a frame boundary
	assign swap_wait = state == ld_idle && head == cmd_swap && !frame_start;
	assign retire = head_valid && !swap_wait;

	// the sender's credits keep at most credit_depth bytes in the queue
	always_ff @(posedge clk_root) begin
		if (byte_valid) begin
			queue[tail_ptr] <= byte_data;
		end
	end

	always_ff @(posedge clk_root) begin
		if (rst) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
		end else begin
			if (byte_valid) begin
				tail_ptr <= (tail_ptr == queue_bits'(credit_depth - 1)) ? '0 : tail_ptr + 1'b1;
			end
			if (retire) begin
				head_ptr <= (head_ptr == queue_bits'(credit_depth - 1)) ? '0 : head_ptr + 1'b1;
			end
			count <= count + count_bits'(byte_valid) - count_bits'(retire);
		end
	end

	always_ff @(posedge clk_root) begin
		if (rst) begin
			state <= ld_idle;
			lane <= 1'b0;
			load_col <= '0;
			wr_en <= 1'b0;
			display_bank <= 1'b0;
			brightness_enable <= '1;
			byte_credit <= 1'b0;
		end else begin
			// credit goes back one cycle after the byte leaves the queue
			byte_credit <= retire;
			wr_en <= 1'b0;
			if (retire) begin
				case (state)
					ld_idle: begin
						case (head)
							cmd_load_row: state <= ld_row;
							cmd_swap: display_bank <= ~display_bank;
							cmd_brightness: state <= ld_bright;
							default: state <= ld_idle;
						endcase
					end
					ld_row: begin
						load_col <= '0;
						lane <= 1'b0;
						state <= ld_pixel;
					end
					ld_pixel: begin
						lane <= ~lane;
						if (lane) begin
							wr_en <= 1'b1;
							load_col <= load_col + 1'b1;
							if (load_col == col_bits'(columns - 1)) begin
								state <= ld_idle;
							end
						end
					end
					default: begin
						brightness_enable <= head[planes-1:0];
						state <= ld_idle;
					end
				endcase
			end
		end
	end

	// pixel assembly with the low byte first
	always_ff @(posedge clk_root) begin
		if (retire && state == ld_row) begin
			load_row <= head[row_bits-1:0];
		end
		if (retire && state == ld_pixel) begin
			if (!lane) begin
				wr_data.bytes.lo <= head;
			end else begin
				wr_data.bytes.hi <= head;
				wr_addr <= {~display_bank, load_row, load_col};
			end
		end
	end

endmodule

//--- logic/led_matrix_pkg.sv
// shared panel geometry, command codes, FSM encodings and pixel word type for the led matrix RTL
package led_matrix_pkg;

	// panel geometry
	localparam int columns = 16;
	localparam int scan_rows = 4;
	localparam int planes = 6;

	localparam int col_bits = $clog2(columns);
	localparam int scan_bits = $clog2(scan_rows);
	// full panel row index over the top and bottom halves
	localparam int row_bits = $clog2(2 * scan_rows);
	localparam int plane_bits = $clog2(planes);
	// {bank, row, column}
	localparam int addr_bits = 1 + row_bits + col_bits;

	// longest on-time is columns << (planes - 1) cycles
	localparam int oe_bits = $clog2((columns << (planes - 1)) + 1);

	// byte channel queue
	localparam int credit_depth = 4;
	localparam int queue_bits = $clog2(credit_depth);
	localparam int count_bits = $clog2(credit_depth + 1);

	// command bytes
	localparam logic [7:0] cmd_load_row = 8'h4C;
	localparam logic [7:0] cmd_swap = 8'h53;
	localparam logic [7:0] cmd_brightness = 8'h42;

	// loader parser states
	localparam logic [1:0] ld_idle = 2'd0;
	localparam logic [1:0] ld_row = 2'd1;
	localparam logic [1:0] ld_pixel = 2'd2;
	localparam logic [1:0] ld_bright = 2'd3;

	// scan sequencer states
	localparam logic [1:0] sq_frame = 2'd0;
	localparam logic [1:0] sq_shift = 2'd1;
	localparam logic [1:0] sq_wait = 2'd2;

	// rgb565 pixel filled bytewise and decoded as colour fields
	typedef union packed {
		struct packed {
			logic [4:0] red;
			logic [5:0] green;
			logic [4:0] blue;
		} field;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
	} pixel_word_u;

endpackage

//--- logic/led_matrix_top.sv
// top level of the led matrix driver, byte command input to HUB75 panel signals
`timescale 1ns/1ps

module led_matrix_top (
	input  logic                                clk_root,
	input  logic                                rst,
	input  logic                                byte_valid,
	input  logic [7:0]                          byte_data,
	output logic                                byte_credit,
	output logic [2:0]                          rgb_top,
	output logic [2:0]                          rgb_bottom,
	output logic [led_matrix_pkg::scan_bits-1:0] row_addr,
	output logic                                pixel_clk,
	output logic                                row_latch,
	output logic                                output_enable
);
	import led_matrix_pkg::*;

	logic frame_start;
	logic wr_en;
	logic [addr_bits-1:0] wr_addr;
	pixel_word_u wr_data;
	logic display_bank;
	logic [planes-1:0] brightness_enable;
	logic [addr_bits-1:0] rd_addr;
	pixel_word_u rd_data;

	logic req_valid;
	logic [col_bits-1:0] req_col;
	logic [scan_bits-1:0] req_row;
	logic [plane_bits-1:0] req_plane;
	logic req_last;

	logic pair_valid;
	pixel_word_u pixel_top;
	pixel_word_u pixel_bottom;
	logic [plane_bits-1:0] pair_plane;
	logic pair_last;
	logic [scan_bits-1:0] pair_row;
	logic latch_done;

	frame_loader loader_i (
		.clk_root(clk_root),
		.rst(rst),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.byte_credit(byte_credit),
		.frame_start(frame_start),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.display_bank(display_bank),
		.brightness_enable(brightness_enable)
	);

	frame_buffer buffer_i (
		.clk_root(clk_root),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	scan_sequencer sequencer_i (
		.clk_root(clk_root),
		.rst(rst),
		.frame_start(frame_start),
		.req_valid(req_valid),
		.req_col(req_col),
		.req_row(req_row),
		.req_plane(req_plane),
		.req_last(req_last),
		.latch_done(latch_done),
		.output_enable(output_enable)
	);

	pixel_fetch fetch_i (
		.clk_root(clk_root),
		.rst(rst),
		.display_bank(display_bank),
		.req_valid(req_valid),
		.req_col(req_col),
		.req_row(req_row),
		.req_plane(req_plane),
		.req_last(req_last),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.pair_valid(pair_valid),
		.pixel_top(pixel_top),
		.pixel_bottom(pixel_bottom),
		.pair_plane(pair_plane),
		.pair_last(pair_last),
		.pair_row(pair_row)
	);

	bitplane_slice slice_i (
		.clk_root(clk_root),
		.rst(rst),
		.pair_valid(pair_valid),
		.pixel_top(pixel_top),
		.pixel_bottom(pixel_bottom),
		.pair_plane(pair_plane),
		.pair_last(pair_last),
		.pair_row(pair_row),
		.brightness_enable(brightness_enable),
		.rgb_top(rgb_top),
		.rgb_bottom(rgb_bottom),
		.pixel_clk(pixel_clk),
		.row_latch(row_latch),
		.row_addr(row_addr),
		.latch_done(latch_done)
	);

endmodule

//--- logic/pixel_fetch.sv
// reads the top and bottom pixel of each request from the front bank and aligns the request fields
`timescale 1ns/1ps

module pixel_fetch (
	input  logic                                 clk_root,
	input  logic                                 rst,
	input  logic                                 display_bank,
	input  logic                                 req_valid,
	input  logic [led_matrix_pkg::col_bits-1:0]   req_col,
	input  logic [led_matrix_pkg::scan_bits-1:0]  req_row,
	input  logic [led_matrix_pkg::plane_bits-1:0] req_plane,
	input  logic                                 req_last,
	output logic [led_matrix_pkg::addr_bits-1:0]  rd_addr,
	input  led_matrix_pkg::pixel_word_u          rd_data,
	output logic                                 pair_valid,
	output led_matrix_pkg::pixel_word_u          pixel_top,
	output led_matrix_pkg::pixel_word_u          pixel_bottom,
	output logic [led_matrix_pkg::plane_bits-1:0] pair_plane,
	output logic                                 pair_last,
	output logic [led_matrix_pkg::scan_bits-1:0]  pair_row
);
	import led_matrix_pkg::*;

	logic s1_valid;
	logic s1_bank;
	logic [col_bits-1:0] s1_col;
	logic [scan_bits-1:0] s1_row;
	logic [plane_bits-1:0] s1_plane;
	logic s1_last;

	logic s2_valid;
	logic [scan_bits-1:0] s2_row;
	logic [plane_bits-1:0] s2_plane;
	logic s2_last;
	pixel_word_u top_q;

	logic [row_bits-1:0] bottom_row;

	assign bottom_row = row_bits'(s1_row) + row_bits'(scan_rows);

	// top half in the request cycle, bottom half one cycle later
	assign rd_addr = s1_valid ? {s1_bank, bottom_row, s1_col}
		: {display_bank, row_bits'(req_row), req_col};

	always_ff @(posedge clk_root) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			pair_valid <= 1'b0;
		end else begin
			s1_valid <= req_valid;
			s2_valid <= s1_valid;
			pair_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk_root) begin
		s1_bank <= display_bank;
		s1_col <= req_col;
		s1_row <= req_row;
		s1_plane <= req_plane;
		s1_last <= req_last;

		s2_row <= s1_row;
		s2_plane <= s1_plane;
		s2_last <= s1_last;
		// top word is on rd_data while stage 1 holds the request
		top_q <= rd_data;

		pair_row <= s2_row;
		pair_plane <= s2_plane;
		pair_last <= s2_last;
		pixel_top <= top_q;
		pixel_bottom <= rd_data;
	end

endmodule

//--- logic/scan_sequencer.sv
// walks columns, bit planes and scan rows, issuing pixel requests and timing the output-enable window
`timescale 1ns/1ps

module scan_sequencer (
	input  logic                                 clk_root,
	input  logic                                 rst,
	output logic                                 frame_start,
	output logic                                 req_valid,
	output logic [led_matrix_pkg::col_bits-1:0]   req_col,
	output logic [led_matrix_pkg::scan_bits-1:0]  req_row,
	output logic [led_matrix_pkg::plane_bits-1:0] req_plane,
	output logic                                 req_last,
	input  logic                                 latch_done,
	output logic                                 output_enable
);
	import led_matrix_pkg::*;

	logic [1:0] state;
	logic phase;
	logic [col_bits-1:0] col;
	logic [scan_bits-1:0] row;
	logic [plane_bits-1:0] plane;
	logic [oe_bits-1:0] oe_count;
	logic last_col;

	assign last_col = col == col_bits'(columns - 1);
	assign frame_start = state == sq_frame;

	// the last column is held back until the previous plane's on-time is over,
	// so the next latch never lands inside an enable window
	assign req_valid = state == sq_shift && !phase && (!last_col || oe_count == '0);
	assign req_col = col;
	assign req_row = row;
	assign req_plane = plane;
	assign req_last = last_col;

	assign output_enable = oe_count != '0;

	always_ff @(posedge clk_root) begin
		if (rst) begin
			state <= sq_frame;
			phase <= 1'b0;
			col <= '0;
			row <= '0;
			plane <= '0;
			oe_count <= '0;
		end else begin
			if (oe_count != '0) begin
				oe_count <= oe_count - 1'b1;
			end
			case (state)
				sq_frame: begin
					phase <= 1'b0;
					state <= sq_shift;
				end
				sq_shift: begin
					// one request every second cycle
					if (phase) begin
						phase <= 1'b0;
					end else if (req_valid) begin
						phase <= 1'b1;
						if (last_col) begin
							state <= sq_wait;
						end else begin
							col <= col + 1'b1;
						end
					end
				end
				sq_wait: begin
					if (latch_done) begin
						// binary weighted on-time for the plane just latched
						oe_count <= oe_bits'(columns) << plane;
						col <= '0;
						phase <= 1'b0;
						if (plane == plane_bits'(planes - 1)) begin
							plane <= '0;
							if (row == scan_bits'(scan_rows - 1)) begin
								row <= '0;
								state <= sq_frame;
							end else begin
								row <= row + 1'b1;
								state <= sq_shift;
							end
						end else begin
							plane <= plane + 1'b1;
							state <= sq_shift;
						end
					end
				end
				default: state <= sq_frame;
			endcase
		end
	end

endmodule

//--- sim.f
logic/led_matrix_pkg.sv
logic/frame_loader.sv
logic/frame_buffer.sv
logic/scan_sequencer.sv
logic/pixel_fetch.sv
logic/bitplane_slice.sv
logic/led_matrix_top.sv
verification/led_matrix_props.sv
verification/led_matrix_tb.sv

//--- verification/led_matrix_props.sv
// panel control assertions, bound to the led matrix top level by the testbench
`timescale 1ns/1ps

module led_matrix_props (
	input logic clk_root,
	input logic rst,
	input logic byte_credit,
	input logic pixel_clk,
	input logic row_latch,
	input logic output_enable
);

	int failures = 0;

	// the panel must be blanked while a row is latched
	latch_blanked: assert property (@(posedge clk_root) disable iff (rst)
		!(row_latch && output_enable))
		else begin
			failures++;
			$error("row_latch and output_enable are high in the same cycle");
		end

	latch_without_clock: assert property (@(posedge clk_root) disable iff (rst)
		!(pixel_clk && row_latch))
		else begin
			failures++;
			$error("pixel_clk is high in a row_latch cycle");
		end

	// first cycle out of reset
	quiet_after_reset: assert property (@(posedge clk_root)
		$fell(rst) |-> (!byte_credit && !output_enable && !row_latch))
		else begin
			failures++;
			$error("byte_credit, output_enable or row_latch high right after reset");
		end

endmodule

//--- verification/led_matrix_stimulus.mem
// each record is opcode(8) argument(8) seed(16) in hex
// opcodes 01 load row, 02 swap, 03 brightness mask, 04 check frame with expected mask, 05 raw byte
043f0000
01001a2b
01013c4d
01025e6f
01037a81
01049c13
0105b4e7
0106d209
0107f3a5
02000000
043f0000
01000f1e
01022d3c
01044b5a
01066978
02000000
01018796
0103a5b4
043f0000
032d0000
042d0000
057e0000
033f0000
043f0000

//--- verification/led_matrix_tb.sv
// testbench for the led matrix driver, replays the stimulus file and models the panel to check it
`timescale 1ns/1ps

module led_matrix_tb;
	import led_matrix_pkg::*;

	localparam int pixels = columns * 2 * scan_rows;
	localparam int frame_latches = scan_rows * planes;
	localparam int wait_limit = 20000;
	localparam int max_records = 64;

	logic clk_root;
	logic rst;
	logic byte_valid;
	logic [7:0] byte_data;
	logic byte_credit;
	logic [2:0] rgb_top;
	logic [2:0] rgb_bottom;
	logic [scan_bits-1:0] row_addr;
	logic pixel_clk;
	logic row_latch;
	logic output_enable;

	logic [31:0] records [max_records];
	// panel model of both banks and the images around a swap
	logic [15:0] bank_img [2][pixels];
	logic [15:0] old_img [pixels];
	logic [15:0] new_img [pixels];
	logic front;
	logic [planes-1:0] model_mask;
	logic [31:0] lfsr_state;

	int errors;
	int sent_count;
	int returned_count;
	int latch_count;
	int col_index;
	int oe_cycles;
	int since_latch;
	logic [2:0] top_bits [columns];
	logic [2:0] bottom_bits [columns];
	logic timed_out;

	int check_from;
	logic check_active;
	logic [planes-1:0] check_mask;

	logic atom_armed;
	logic atom_frame_valid;
	logic frame_old_ok;
	logic frame_new_ok;
	logic seen_new;
	logic [planes-1:0] atom_mask;
	logic swap_tracking;
	int swap_index;

	led_matrix_top dut_i (
		.clk_root(clk_root),
		.rst(rst),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.byte_credit(byte_credit),
		.rgb_top(rgb_top),
		.rgb_bottom(rgb_bottom),
		.row_addr(row_addr),
		.pixel_clk(pixel_clk),
		.row_latch(row_latch),
		.output_enable(output_enable)
	);

	bind led_matrix_top led_matrix_props props_i (
		.clk_root(clk_root),
		.rst(rst),
		.byte_credit(byte_credit),
		.pixel_clk(pixel_clk),
		.row_latch(row_latch),
		.output_enable(output_enable)
	);

	always #2 clk_root = ~clk_root;

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// expected {blue, green, red} bit of one rgb565 word for a plane
	function automatic logic [2:0] colour_bits(input logic [15:0] px, input int plane,
			input logic [planes-1:0] mask);
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
		logic rb;
		logic bb;
		r = px[15:11];
		g = px[10:5];
		b = px[4:0];
		if (!mask[plane]) begin
			return 3'b000;
		end
		// plane 0 of a 5 bit channel is a copy of its msb
		rb = (plane == 0) ? r[4] : r[plane-1];
		bb = (plane == 0) ? b[4] : b[plane-1];
		return {bb, g[plane], rb};
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[14:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic next_drive_slot();
		@(posedge clk_root);
		#1;
	endtask

	task automatic send_byte(input logic [7:0] value);
		int waited;
		logic [15:0] gap;
		waited = 0;
		while (sent_count - returned_count >= credit_depth && !timed_out) begin
			next_drive_slot();
			waited++;
			if (waited > wait_limit) begin
				$display("timeout: no credit came back for byte %0d", sent_count);
				errors++;
				timed_out = 1'b1;
			end
		end
		if (!timed_out) begin
			byte_valid = 1'b1;
			byte_data = value;
			sent_count++;
			next_drive_slot();
			byte_valid = 1'b0;
			draw_bits(2, gap);
			repeat (gap) next_drive_slot();
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (returned_count != sent_count && !timed_out) begin
			next_drive_slot();
			waited++;
			if (waited > wait_limit) begin
				$display("timeout: %0d queued bytes never drained", sent_count - returned_count);
				errors++;
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic wait_latches(input int target);
		int waited;
		waited = 0;
		while (latch_count < target && !timed_out) begin
			next_drive_slot();
			waited++;
			if (waited > wait_limit) begin
				$display("timeout: panel stopped latching rows at latch %0d", latch_count);
				errors++;
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic load_row(input int row, input logic [15:0] seed);
		logic [15:0] px;
		lfsr_state = 32'h5f9cc1f7 ^ {16'h0000, seed};
		send_byte(cmd_load_row);
		send_byte(row[7:0]);
		for (int c = 0; c < columns; c++) begin
			draw_bits(16, px);
			bank_img[!front][row * columns + c] = px;
			send_byte(px[7:0]);
			send_byte(px[15:8]);
		end
	endtask

	task automatic swap_banks();
		for (int i = 0; i < pixels; i++) begin
			old_img[i] = bank_img[front][i];
			new_img[i] = bank_img[!front][i];
		end
		atom_mask = model_mask;
		seen_new = 1'b0;
		atom_frame_valid = 1'b0;
		atom_armed = 1'b1;
		swap_index = sent_count;
		swap_tracking = 1'b1;
		front = !front;
		send_byte(cmd_swap);
	endtask

	task automatic set_brightness(input logic [7:0] mask);
		model_mask = mask[planes-1:0];
		send_byte(cmd_brightness);
		send_byte({2'b00, mask[planes-1:0]});
	endtask

	task automatic check_frame(input logic [planes-1:0] mask);
		if (mask != model_mask) begin
			$display("stimulus check mask %h disagrees with the commands sent (%h)", mask,
				model_mask);
			errors++;
		end
		wait_drain();
		// a whole frame that starts after the last command took effect
		if (sent_count == 0 && latch_count == 0) begin
			check_from = 0;
		end else begin
			check_from = (latch_count / frame_latches + 1) * frame_latches;
		end
		check_mask = mask;
		check_active = 1'b1;
		wait_latches(check_from + frame_latches);
		check_active = 1'b0;
		if (atom_armed && !seen_new && !timed_out) begin
			$display("the new image never appeared after the swap");
			errors++;
		end
		atom_armed = 1'b0;
		swap_tracking = 1'b0;
	endtask

	task automatic finish_latch();
		int row;
		int plane;
		int top_idx;
		int bottom_idx;
		logic [2:0] exp_top;
		logic [2:0] exp_bottom;
		row = (latch_count % frame_latches) / planes;
		plane = latch_count % planes;
		if (col_index != columns) begin
			$display("latch %0d came after %0d pixel clocks instead of %0d", latch_count,
				col_index, columns);
			errors++;
		end
		if (row_addr != row) begin
			$display("Mismatch row_addr latch %0d: got %h expected %h", latch_count, row_addr,
				row);
			errors++;
		end
		// on-time of the previous plane
		if (latch_count > 0 && oe_cycles != (columns << ((latch_count - 1) % planes))) begin
			$display("Mismatch output_enable cycles before latch %0d: got %h expected %h",
				latch_count, oe_cycles, columns << ((latch_count - 1) % planes));
			errors++;
		end
		if (latch_count % frame_latches == 0) begin
			atom_frame_valid = atom_armed;
			frame_old_ok = 1'b1;
			frame_new_ok = 1'b1;
		end
		for (int c = 0; c < columns; c++) begin
			top_idx = row * columns + c;
			bottom_idx = (row + scan_rows) * columns + c;
			if (check_active && latch_count >= check_from
					&& latch_count < check_from + frame_latches) begin
				exp_top = colour_bits(bank_img[front][top_idx], plane, check_mask);
				exp_bottom = colour_bits(bank_img[front][bottom_idx], plane, check_mask);
				if (top_bits[c] !== exp_top) begin
					$display("Mismatch rgb_top latch %0d col %0d: got %h expected %h",
						latch_count, c, top_bits[c], exp_top);
					errors++;
				end
				if (bottom_bits[c] !== exp_bottom) begin
					$display("Mismatch rgb_bottom latch %0d col %0d: got %h expected %h",
						latch_count, c, bottom_bits[c], exp_bottom);
					errors++;
				end
			end
			if (top_bits[c] !== colour_bits(old_img[top_idx], plane, atom_mask)
					|| bottom_bits[c] !== colour_bits(old_img[bottom_idx], plane, atom_mask)) begin
				frame_old_ok = 1'b0;
			end
			if (top_bits[c] !== colour_bits(new_img[top_idx], plane, atom_mask)
					|| bottom_bits[c] !== colour_bits(new_img[bottom_idx], plane, atom_mask)) begin
				frame_new_ok = 1'b0;
			end
		end
		// end of a frame inside a swap window
		if (latch_count % frame_latches == frame_latches - 1 && atom_frame_valid && atom_armed) begin
			if (frame_new_ok) begin
				seen_new = 1'b1;
			end else if (!frame_old_ok) begin
				$display("frame %0d mixes the images from before and after the swap",
					latch_count / frame_latches);
				errors++;
			end else if (seen_new) begin
				$display("old image came back in frame %0d after the swap",
					latch_count / frame_latches);
				errors++;
			end
		end
		latch_count++;
		col_index = 0;
		oe_cycles = 0;
		since_latch = 0;
	endtask

	// panel side sampled on the falling edge
	always @(negedge clk_root) begin
		if (rst) begin
			returned_count = 0;
			latch_count = 0;
			col_index = 0;
			oe_cycles = 0;
			since_latch = 0;
		end else begin
			since_latch++;
			if (output_enable) begin
				oe_cycles++;
			end
			if (byte_credit) begin
				if (swap_tracking && returned_count == swap_index
						&& (latch_count % frame_latches != 0 || since_latch > 3)) begin
					$display("swap took effect %0d cycles after latch %0d, not at a frame start",
						since_latch, latch_count);
					errors++;
				end
				returned_count++;
				if (returned_count > sent_count) begin
					$display("credit surplus, %0d credits returned for %0d bytes sent",
						returned_count, sent_count);
					errors++;
				end
			end
			if (pixel_clk) begin
				if (col_index < columns) begin
					top_bits[col_index] = rgb_top;
					bottom_bits[col_index] = rgb_bottom;
				end else begin
					$display("more than %0d pixel clocks before latch %0d", columns, latch_count);
					errors++;
				end
				col_index++;
			end
			if (row_latch) begin
				finish_latch();
			end
		end
	end

	initial begin
		int n;
		logic [7:0] op;
		logic [7:0] arg;
		logic [15:0] seed;
		clk_root = 1'b0;
		rst = 1'b1;
		byte_valid = 1'b0;
		byte_data = 8'h00;
		errors = 0;
		sent_count = 0;
		returned_count = 0;
		latch_count = 0;
		front = 1'b0;
		model_mask = '1;
		lfsr_state = 32'h5f9cc1f7;
		timed_out = 1'b0;
		check_active = 1'b0;
		check_from = 0;
		check_mask = '1;
		atom_armed = 1'b0;
		atom_mask = '1;
		seen_new = 1'b0;
		swap_tracking = 1'b0;
		swap_index = 0;
		for (int i = 0; i < pixels; i++) begin
			bank_img[0][i] = 16'h0000;
			bank_img[1][i] = 16'h0000;
			old_img[i] = 16'h0000;
			new_img[i] = 16'h0000;
		end
		for (int i = 0; i < max_records; i++) begin
			records[i] = 32'h0;
		end
		$readmemh("verification/led_matrix_stimulus.mem", records);

		repeat (5) @(posedge clk_root);
		#1;
		rst = 1'b0;

		n = 0;
		while (n < max_records && records[n][31:24] != 8'h00 && !timed_out) begin
			op = records[n][31:24];
			arg = records[n][23:16];
			seed = records[n][15:0];
			case (op)
				8'h01: load_row(arg, seed);
				8'h02: swap_banks();
				8'h03: set_brightness(arg);
				8'h04: check_frame(arg[planes-1:0]);
				8'h05: send_byte(arg);
				default: begin
					$display("record %0d has an unknown opcode %h", n, op);
					errors++;
				end
			endcase
			n++;
		end
		if (n == 0) begin
			$display("no stimulus records were read");
			errors++;
		end
		// bound assertion failures count as errors of the run
		errors += dut_i.props_i.failures;

		$display("run complete: %0d errors, %0d records, %0d bytes sent, %0d latches seen",
			errors, n, sent_count, latch_count);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
